// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log

cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -j 0 --top-module board_tb \
  -f verilog.f -o board_sim &&
obj_dir/board_sim +verilator+error+limit+10 > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q '^\*\*\* PASSED \*\*\*$' sim.log && echo "simulation passed" ||
  { echo "simulation did not pass"; exit 1; }

// ==== src/board_pkg.sv ====
package board_pkg;

  // bus address width, byte addressed
  localparam int addr_width = 8;

  // upper half of the address space (bit 7 set) belongs to I/O
  localparam logic [addr_width-1:0] io_led_addr  = 8'h80; // byte: led, word: lcd+led
  localparam logic [addr_width-1:0] io_lcd_addr  = 8'h81; // upper data byte
  localparam logic [addr_width-1:0] io_gpio_addr = 8'h82; // lower data byte

  // led matrix rows, one active at a time
  localparam int led_rows = 5;

endpackage

// ==== src/board_top.sv ====
module board_top #(
  parameter int          dmem_words  = 64,
  parameter int unsigned scan_period = 27000,
  parameter int unsigned gap_on      = 100,
  parameter int unsigned gap_off     = 2000
) (
  input  logic                         sys_clk,
  input  logic                         rst_n,
  input  logic [board_pkg::addr_width-1:0] mem_addr,
  input  logic                         mem_wr,
  input  logic                         mem_byt,
  input  logic [15:0]                  wr_data,
  output logic [15:0]                  rd_data,
  input  logic [15:0]                  dbg_stack,
  input  logic [7:0]                   dbg_state,
  input  logic [7:0]                   dbg_ip,
  output logic [board_pkg::led_rows-1:0]   led_row,
  output logic [7:0]                   led_col,
  output logic                         lcd_e,
  output logic                         lcd_rw,
  output logic                         lcd_rs,
  output logic [3:0]                   lcd_db,
  output logic [7:0]                   gpio
);

  logic [15:0] mem_data;
  logic [7:0]  io_led;
  logic [7:0]  io_lcd;
  logic [7:0]  io_gpio;

  data_mem #(
    .dmem_words(dmem_words)
  ) i_data_mem (
    .sys_clk  (sys_clk),
    .rst_n    (rst_n),
    .mem_addr (mem_addr),
    .mem_wr   (mem_wr),
    .mem_byt  (mem_byt),
    .wr_data  (wr_data),
    .mem_data (mem_data)
  );

  io_regs i_io_regs (
    .sys_clk  (sys_clk),
    .rst_n    (rst_n),
    .mem_addr (mem_addr),
    .mem_wr   (mem_wr),
    .mem_byt  (mem_byt),
    .wr_data  (wr_data),
    .mem_data (mem_data),
    .rd_data  (rd_data),
    .io_led   (io_led),
    .io_lcd   (io_lcd),
    .io_gpio  (io_gpio)
  );

  led_matrix_scan #(
    .scan_period (scan_period),
    .gap_on      (gap_on),
    .gap_off     (gap_off)
  ) i_led_matrix_scan (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .dbg_stack (dbg_stack),
    .dbg_state (dbg_state),
    .dbg_ip    (dbg_ip),
    .io_led    (io_led),
    .led_row   (led_row),
    .led_col   (led_col)
  );

  // lcd byte layout: e, rw, rs in the low bits, 4-bit data bus on top
  assign lcd_e  = io_lcd[0];
  assign lcd_rw = io_lcd[1];
  assign lcd_rs = io_lcd[2];
  assign lcd_db = io_lcd[7:4]; // bit 3 unused

  assign gpio = io_gpio;

endmodule

// ==== src/data_mem.sv ====
module data_mem #(
  parameter int dmem_words = 64
) (
  input  logic                         sys_clk,
  input  logic                         rst_n,
  input  logic [board_pkg::addr_width-1:0] mem_addr,
  input  logic                         mem_wr,
  input  logic                         mem_byt,
  input  logic [15:0]                  wr_data,
  output logic [15:0]                  mem_data
);

  import board_pkg::*;

  localparam int idx_width = $clog2(dmem_words);

  logic [15:0]          mem [dmem_words];
  logic [idx_width-1:0] word_idx;
  logic                 wr_en;
  logic [1:0]           lane_we;
  logic [15:0]          lane_data;

  assign word_idx = mem_addr[idx_width:1]; // byte address to word index
  assign wr_en    = mem_wr && !mem_addr[addr_width-1];

  // byte writes copy the low data byte to whichever lane is addressed
  always_comb begin
    if (mem_byt) begin
      lane_we   = {mem_addr[0], ~mem_addr[0]};
      lane_data = {wr_data[7:0], wr_data[7:0]};
    end else begin
      lane_we   = 2'b11;
      lane_data = wr_data;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (wr_en) begin
      if (lane_we[0])
        mem[word_idx][7:0] <= lane_data[7:0];
      if (lane_we[1])
        mem[word_idx][15:8] <= lane_data[15:8];
    end
  end

  // registered read, old word on a same-cycle write
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n)
      mem_data <= '0;
    else
      mem_data <= mem[word_idx];
  end

endmodule

// ==== src/io_regs.sv ====
module io_regs (
  input  logic                         sys_clk,
  input  logic                         rst_n,
  input  logic [board_pkg::addr_width-1:0] mem_addr,
  input  logic                         mem_wr,
  input  logic                         mem_byt,
  input  logic [15:0]                  wr_data,
  input  logic [15:0]                  mem_data,
  output logic [15:0]                  rd_data,
  output logic [7:0]                   io_led,
  output logic [7:0]                   io_lcd,
  output logic [7:0]                   io_gpio
);

  import board_pkg::*;

  logic [addr_width-1:0] mem_addr_d;
  logic                  sel_led_lcd;
  logic                  sel_gpio;
  logic                  sel_io;

  // write decode
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      io_led  <= '0;
      io_lcd  <= '0;
      io_gpio <= '0;
    end else if (mem_wr) begin
      case (mem_addr)
        io_led_addr: begin
          if (mem_byt) begin
            io_led <= wr_data[7:0];
          end else begin
            io_lcd <= wr_data[15:8]; // word write covers both bytes
            io_led <= wr_data[7:0];
          end
        end
        io_lcd_addr:  io_lcd  <= wr_data[15:8];
        io_gpio_addr: io_gpio <= wr_data[7:0];
        default: ;
      endcase
    end
  end

  // address lines up with the registered memory word
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n)
      mem_addr_d <= '0;
    else
      mem_addr_d <= mem_addr;
  end

  // bit 0 ignored, a word read covers both bytes
  assign sel_led_lcd = mem_addr_d[addr_width-1:1] == io_led_addr[addr_width-1:1];
  assign sel_gpio    = mem_addr_d[addr_width-1:1] == io_gpio_addr[addr_width-1:1];
  assign sel_io      = mem_addr_d[addr_width-1];

  always_comb begin
    if (sel_led_lcd)
      rd_data = {io_lcd, io_led};
    else if (sel_gpio)
      rd_data = {8'h00, io_gpio};
    else if (sel_io)
      rd_data = 16'h0000; // unmapped io
    else
      rd_data = mem_data;
  end

endmodule

// ==== src/led_matrix_scan.sv ====
module led_matrix_scan #(
  parameter int unsigned scan_period = 27000,
  parameter int unsigned gap_on      = 100,
  parameter int unsigned gap_off     = 2000
) (
  input  logic                       sys_clk,
  input  logic                       rst_n,
  input  logic [15:0]                dbg_stack,
  input  logic [7:0]                 dbg_state,
  input  logic [7:0]                 dbg_ip,
  input  logic [7:0]                 io_led,
  output logic [board_pkg::led_rows-1:0] led_row,
  output logic [7:0]                 led_col
);

  import board_pkg::*;

  localparam int cnt_width = $clog2(scan_period);
  localparam int row_width = $clog2(led_rows);

  localparam logic [cnt_width-1:0] last_cnt = cnt_width'(scan_period - 1);
  localparam logic [cnt_width-1:0] win_lo   = cnt_width'(gap_on);
  localparam logic [cnt_width-1:0] win_hi   = cnt_width'(scan_period - gap_off);
  localparam logic [row_width-1:0] last_row = row_width'(led_rows - 1);

  logic [cnt_width-1:0] cnt;
  logic [row_width-1:0] row_idx;
  logic                 row_on;

  // period counter
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n)
      cnt <= '0;
    else if (cnt == last_cnt)
      cnt <= '0;
    else
      cnt <= cnt + 1'b1;
  end

  // next row at the start of each period
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      row_idx <= '0;
    end else if (cnt == '0) begin
      if (row_idx == last_row)
        row_idx <= '0;
      else
        row_idx <= row_idx + 1'b1;
    end
  end

  // dark gap at both ends of the period so neighbours don't ghost
  assign row_on = (cnt >= win_lo) && (cnt < win_hi);

  always_comb begin
    led_row = '1; // rows are active low
    if (row_on)
      led_row[row_idx] = 1'b0;
  end

  always_comb begin
    case (row_idx)
      3'd0:    led_col = dbg_stack[15:8];
      3'd1:    led_col = dbg_stack[7:0];
      3'd2:    led_col = dbg_state;
      3'd3:    led_col = dbg_ip;
      3'd4:    led_col = io_led;
      default: led_col = 8'h00;
    endcase
  end

endmodule

// ==== verification/board_chk.sv ====
module board_chk #(
  parameter int unsigned scan_period = 40,
  parameter int unsigned gap_on      = 4,
  parameter int unsigned gap_off     = 8
) (
  input logic                             sys_clk,
  input logic                             rst_n,
  input logic [board_pkg::addr_width-1:0] mem_addr,
  input logic                             mem_wr,
  input logic                             mem_byt,
  input logic [15:0]                      wr_data,
  input logic [15:0]                      rd_data,
  input logic [15:0]                      dbg_stack,
  input logic [7:0]                       dbg_state,
  input logic [7:0]                       dbg_ip,
  input logic [board_pkg::led_rows-1:0]   led_row,
  input logic [7:0]                       led_col,
  input logic                             lcd_e,
  input logic                             lcd_rw,
  input logic                             lcd_rs,
  input logic [3:0]                       lcd_db,
  input logic [7:0]                       gpio
);

  import board_pkg::*;

  logic [15:0]         sh_mem [64];
  logic [63:0]         sh_vld;   // word holds a known value
  logic [7:0]          sh_led;
  logic [7:0]          sh_lcd;
  logic [7:0]          sh_gpio;
  logic [7:0]          rd_addr;
  logic [15:0]         rd_word;
  logic                rd_vld;
  logic [15:0]         rd_exp;
  int unsigned         cyc;      // cycles since reset release
  int unsigned         ph;
  int unsigned         row;
  logic [led_rows-1:0] row_exp;
  logic [7:0]          col_exp;
  logic                fail_rd  = 1'b0;
  logic                fail_io  = 1'b0;
  logic                fail_row = 1'b0;
  logic                fail_col = 1'b0;
  logic                chk_failed;

  always_ff @(posedge sys_clk) begin
    if (mem_wr && !mem_addr[7]) begin
      if (!mem_byt)
        sh_mem[mem_addr[6:1]] <= wr_data;
      else if (mem_addr[0])
        sh_mem[mem_addr[6:1]][15:8] <= wr_data[7:0];
      else
        sh_mem[mem_addr[6:1]][7:0] <= wr_data[7:0];
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      sh_vld  <= '0;
      sh_led  <= '0;
      sh_lcd  <= '0;
      sh_gpio <= '0;
      rd_addr <= '0;
      rd_word <= '0;
      rd_vld  <= 1'b0;
      cyc     <= 0;
    end else begin
      cyc     <= cyc + 1;
      rd_addr <= mem_addr;
      rd_word <= sh_mem[mem_addr[6:1]]; // old word on a same-cycle write
      rd_vld  <= mem_addr[7] || sh_vld[mem_addr[6:1]];
      if (mem_wr && !mem_addr[7] && !mem_byt)
        sh_vld[mem_addr[6:1]] <= 1'b1;
      if (mem_wr && mem_addr == io_led_addr) begin
        sh_led <= wr_data[7:0];
        if (!mem_byt)
          sh_lcd <= wr_data[15:8];
      end
      if (mem_wr && mem_addr == io_lcd_addr)
        sh_lcd <= wr_data[15:8];
      if (mem_wr && mem_addr == io_gpio_addr)
        sh_gpio <= wr_data[7:0];
    end
  end

  always_comb begin
    case (rd_addr)
      8'h80, 8'h81: rd_exp = {sh_lcd, sh_led};
      8'h82, 8'h83: rd_exp = {8'h00, sh_gpio};
      default:      rd_exp = rd_addr[7] ? 16'h0000 : rd_word;
    endcase
  end

  // row k lights during the period that starts at cycle (k-1)*P+1
  always_comb begin
    ph      = cyc % scan_period;
    row     = ((cyc + scan_period - 1) / scan_period) % led_rows;
    row_exp = '1;
    if (ph >= gap_on && ph < scan_period - gap_off)
      row_exp = ~({{(led_rows-1){1'b0}}, 1'b1} << row);
    case (row)
      0:       col_exp = dbg_stack[15:8];
      1:       col_exp = dbg_stack[7:0];
      2:       col_exp = dbg_state;
      3:       col_exp = dbg_ip;
      default: col_exp = sh_led;
    endcase
  end

  assign chk_failed = fail_rd | fail_io | fail_row | fail_col;

  a_rd_data: assert property (@(posedge sys_clk) disable iff (!rst_n)
    rd_vld |-> rd_data == rd_exp)
    else begin
      $error("CHECK FAILED t=%0t rd_data %h expected %h addr %h", $time,
             $sampled(rd_data), $sampled(rd_exp), $sampled(rd_addr));
      fail_rd = 1'b1;
    end

  a_io_pins: assert property (@(posedge sys_clk)
    {lcd_db, lcd_rs, lcd_rw, lcd_e} == {sh_lcd[7:4], sh_lcd[2:0]} && gpio == sh_gpio)
    else begin
      $error("CHECK FAILED t=%0t lcd/gpio pins do not match lcd %h gpio %h", $time,
             $sampled(sh_lcd), $sampled(sh_gpio));
      fail_io = 1'b1;
    end

  a_row: assert property (@(posedge sys_clk) led_row == row_exp)
    else begin
      $error("CHECK FAILED t=%0t led_row %b expected %b", $time,
             $sampled(led_row), $sampled(row_exp));
      fail_row = 1'b1;
    end

  a_col: assert property (@(posedge sys_clk) led_col == col_exp)
    else begin
      $error("CHECK FAILED t=%0t led_col %h expected %h", $time,
             $sampled(led_col), $sampled(col_exp));
      fail_col = 1'b1;
    end

endmodule

bind board_top board_chk #(
  .scan_period (scan_period),
  .gap_on      (gap_on),
  .gap_off     (gap_off)
) i_chk (
  .sys_clk   (sys_clk),
  .rst_n     (rst_n),
  .mem_addr  (mem_addr),
  .mem_wr    (mem_wr),
  .mem_byt   (mem_byt),
  .wr_data   (wr_data),
  .rd_data   (rd_data),
  .dbg_stack (dbg_stack),
  .dbg_state (dbg_state),
  .dbg_ip    (dbg_ip),
  .led_row   (led_row),
  .led_col   (led_col),
  .lcd_e     (lcd_e),
  .lcd_rw    (lcd_rw),
  .lcd_rs    (lcd_rs),
  .lcd_db    (lcd_db),
  .gpio      (gpio)
);

// ==== verification/board_tb.sv ====
module board_tb;

  import board_pkg::*;

  localparam int unsigned scan_period = 40;
  localparam int unsigned gap_on      = 4;
  localparam int unsigned gap_off     = 8;
  localparam int          wait_limit  = 1000; // cycles

  logic                  sys_clk;
  logic                  rst_n;
  logic [addr_width-1:0] mem_addr;
  logic                  mem_wr;
  logic                  mem_byt;
  logic [15:0]           wr_data;
  logic [15:0]           rd_data;
  logic [15:0]           dbg_stack;
  logic [7:0]            dbg_state;
  logic [7:0]            dbg_ip;
  logic [led_rows-1:0]   led_row;
  logic [7:0]            led_col;
  logic                  lcd_e;
  logic                  lcd_rw;
  logic                  lcd_rs;
  logic [3:0]            lcd_db;
  logic [7:0]            gpio;
  logic [31:0]           rng_state;

  board_top #(
    .dmem_words  (64),
    .scan_period (scan_period),
    .gap_on      (gap_on),
    .gap_off     (gap_off)
  ) i_dut (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .mem_addr  (mem_addr),
    .mem_wr    (mem_wr),
    .mem_byt   (mem_byt),
    .wr_data   (wr_data),
    .rd_data   (rd_data),
    .dbg_stack (dbg_stack),
    .dbg_state (dbg_state),
    .dbg_ip    (dbg_ip),
    .led_row   (led_row),
    .led_col   (led_col),
    .lcd_e     (lcd_e),
    .lcd_rw    (lcd_rw),
    .lcd_rs    (lcd_rs),
    .lcd_db    (lcd_db),
    .gpio      (gpio)
  );

  always #2 sys_clk = ~sys_clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("*** FAILED ***");
    $fatal(1, "%s", why);
  endtask

  // one bus cycle, inputs change just after the rising edge
  task automatic drive_bus(input logic [7:0] addr, input logic wr, input logic byt,
                           input logic [15:0] data);
    logic [31:0] r;
    @(posedge sys_clk);
    #1;
    mem_addr = addr;
    mem_wr   = wr;
    mem_byt  = byt;
    wr_data  = data;
    r = next_random();
    if (r[2:0] == 3'd0) begin // cpu debug state moves now and then
      dbg_stack = r[31:16];
      dbg_state = r[15:8];
      dbg_ip    = r[11:4];
    end
  endtask

  task automatic read_range(input logic [7:0] lo, input logic [7:0] hi);
    logic [7:0] a;
    a = lo;
    drive_bus(a, 1'b0, 1'b0, 16'h0000);
    while (a != hi) begin
      a = a + 8'd1;
      drive_bus(a, 1'b0, 1'b0, 16'h0000);
    end
  endtask

  task automatic wait_row_active(input logic [2:0] row);
    logic [31:0] r;
    int          n;
    n = 0;
    while (led_row[row] !== 1'b0 && n < wait_limit) begin
      r = next_random();
      drive_bus(r[7:0], 1'b0, 1'b0, 16'h0000);
      n++;
    end
    if (n >= wait_limit)
      stop_with_failure($sformatf("timeout waiting for led row %0d to light", row));
  endtask

  always @(posedge sys_clk) begin
    if (i_dut.i_chk.chk_failed)
      stop_with_failure("stopped after a failed check");
  end

  initial begin
    logic [31:0] r;
    logic [7:0]  a;
    sys_clk   = 1'b0;
    rst_n     = 1'b1;
    mem_addr  = '0;
    mem_wr    = 1'b0;
    mem_byt   = 1'b0;
    wr_data   = '0;
    dbg_stack = '0;
    dbg_state = '0;
    dbg_ip    = '0;
    rng_state = 32'd62;
    #1;
    rst_n = 1'b0;
    repeat (3) @(posedge sys_clk);
    #1;
    rst_n = 1'b1;

    // every word gets a known value first
    for (int i = 0; i < 64; i++) begin
      a = {1'b0, i[5:0], 1'b0};
      drive_bus(a, 1'b1, 1'b0, {~a, a ^ 8'ha5});
    end
    read_range(8'h00, 8'h7f);

    for (int i = 0; i < 400; i++) begin
      r = next_random();
      a = {1'b0, r[6:0]};
      case (r[9:8])
        2'd0:    drive_bus(a, 1'b1, 1'b0, r[31:16]);
        2'd1:    drive_bus(a, 1'b1, 1'b1, r[31:16]);
        default: drive_bus(a, 1'b0, 1'b0, 16'h0000);
      endcase
    end

    drive_bus(8'h80, 1'b1, 1'b1, 16'h12a5); // led only
    read_range(8'h80, 8'h83);
    drive_bus(8'h80, 1'b1, 1'b0, 16'h3c96); // lcd and led
    read_range(8'h80, 8'h83);
    drive_bus(8'h81, 1'b1, 1'b1, 16'hf00f);
    drive_bus(8'h82, 1'b1, 1'b0, 16'hbe5a);
    read_range(8'h80, 8'h83);

    // unmapped io space, then memory must be unchanged
    for (int i = 8'h84; i < 256; i++) begin
      r = next_random();
      drive_bus(8'(i), 1'b1, r[16], r[15:0]);
    end
    read_range(8'h80, 8'hff);
    read_range(8'h00, 8'h7f);

    for (int i = 0; i < 300; i++) begin
      r = next_random();
      drive_bus(r[7:0], r[8], r[9], r[31:16]);
    end

    for (int round = 0; round < 2; round++) begin
      for (int k = 0; k < led_rows; k++) begin
        if (k == led_rows - 1) begin
          r = next_random();
          drive_bus(8'h80, 1'b1, 1'b1, r[15:0]);
        end
        wait_row_active(3'(k));
      end
    end
    drive_bus(8'h00, 1'b0, 1'b0, 16'h0000);
    repeat (2) @(posedge sys_clk);

    if (i_dut.i_chk.chk_failed) begin
      stop_with_failure("a check failed during the run");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

// ==== verilog.f ====
src/board_pkg.sv
src/data_mem.sv
src/io_regs.sv
src/led_matrix_scan.sv
src/board_top.sv
verification/board_chk.sv
verification/board_tb.sv
